// File: hw/buf_ring_pkg.sv
`default_nettype none

package buf_ring_pkg;

    // Three shared buffers circulate, so no queue ever holds more than three tokens
    localparam int BUF_COUNT = 3;
    localparam int QUEUE_DEPTH = BUF_COUNT;

    // Pointer and occupancy widths for a queue of QUEUE_DEPTH entries
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // A token names one buffer, zero means the agent has nothing connected
    typedef logic [1:0] buf_tok_t;

    localparam buf_tok_t TOK_NONE = 2'd0;
    localparam buf_tok_t TOK_PING = 2'd1;
    localparam buf_tok_t TOK_PANG = 2'd2;
    localparam buf_tok_t TOK_PONG = 2'd3;

    // Owner select value driven to each buffer's memory multiplexer
    typedef enum logic [1:0] {AG_NONE, AG_SNOOP, AG_CPU, AG_FWD} agent_e;

    // Result an agent holds until its done-ack arrives
    typedef enum logic [1:0] {RES_NONE, RES_DONE, RES_REJECT} agent_result_e;

    // Handshake state of one agent
    typedef enum logic {HS_IDLE, HS_BUSY} hs_state_e;

    // One-cycle pulses marking how a job ended
    typedef struct packed {
        logic done;
        logic reject;
    } job_event_t;

    // One owner select per buffer
    typedef struct packed {
        agent_e ping;
        agent_e pang;
        agent_e pong;
    } owner_sel_t;

endpackage

`default_nettype wire

// File: hw/token_queue.sv
`timescale 1ns/10ps
`default_nettype none

module token_queue #(
    parameter int NUM_SRC = 1,
    // Set for the snoop queue, which owns every buffer after reset
    parameter bit INIT_FULL = 1'b0
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  enq_i     [NUM_SRC],
    input  buf_ring_pkg::buf_tok_t     enq_tok_i [NUM_SRC],
    input  wire logic                  deq_i,
    output buf_ring_pkg::buf_tok_t     head_o
);

    buf_ring_pkg::buf_tok_t               mem [buf_ring_pkg::QUEUE_DEPTH];
    logic [buf_ring_pkg::PTR_W-1:0]       rd_ptr;
    logic [buf_ring_pkg::PTR_W-1:0]       wr_ptr;
    logic [buf_ring_pkg::CNT_W-1:0]       count;
    logic [buf_ring_pkg::PTR_W-1:0]       wr_addr [NUM_SRC];
    logic [buf_ring_pkg::PTR_W-1:0]       wr_next;
    logic [buf_ring_pkg::CNT_W-1:0]       enq_cnt;
    logic                                 deq_ok;

    // Pointers wrap at QUEUE_DEPTH, which need not be a power of two
    function automatic logic [buf_ring_pkg::PTR_W-1:0] ptr_inc(
        input logic [buf_ring_pkg::PTR_W-1:0] p
    );
        if (p == buf_ring_pkg::PTR_W'(buf_ring_pkg::QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // Each active source takes the next free slot in source order
    always_comb begin
        wr_next = wr_ptr;
        enq_cnt = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            wr_addr[s] = wr_next;
            if (enq_i[s]) begin
                wr_next = ptr_inc(wr_next);
                enq_cnt = enq_cnt + 1'b1;
            end
        end
    end

    // A dequeue on an empty queue has nothing to remove
    assign deq_ok = deq_i && (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= INIT_FULL ? buf_ring_pkg::CNT_W'(buf_ring_pkg::QUEUE_DEPTH) : '0;
            // Reset order is ping, pang, pong from the head
            for (int i = 0; i < buf_ring_pkg::QUEUE_DEPTH; i++) begin
                mem[i] <= INIT_FULL ? buf_ring_pkg::buf_tok_t'(i + 1) : buf_ring_pkg::TOK_NONE;
            end
        end else begin
            for (int s = 0; s < NUM_SRC; s++) begin
                if (enq_i[s]) begin
                    mem[wr_addr[s]] <= enq_tok_i[s];
                end
            end
            wr_ptr <= wr_next;
            if (deq_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + enq_cnt - deq_ok;
        end
    end

    // The head is the buffer this queue's agent is connected to
    assign head_o = (count == '0) ? buf_ring_pkg::TOK_NONE : mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/agent_handshake.sv
`timescale 1ns/10ps
`default_nettype none

module agent_handshake (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       connected_i,
    input  wire logic                       rdy_ack_i,
    input  buf_ring_pkg::agent_result_e     result_i,
    output logic                            rdy_o,
    output logic                            done_ack_o,
    output buf_ring_pkg::job_event_t        job_o
);

    buf_ring_pkg::hs_state_e state_q;
    logic                    start;
    logic                    finish;

    // Ready only while idle and holding a buffer; it stays up until acknowledged
    assign rdy_o = (state_q == buf_ring_pkg::HS_IDLE) && connected_i;

    // The done-ack is the busy state itself, so a result raised while idle waits
    assign done_ack_o = (state_q == buf_ring_pkg::HS_BUSY);

    assign start = rdy_o && rdy_ack_i;

    // Completion pulses are only seen while the ack is up
    assign job_o.done   = done_ack_o && (result_i == buf_ring_pkg::RES_DONE);
    assign job_o.reject = done_ack_o && (result_i == buf_ring_pkg::RES_REJECT);

    // An undefined result code does not end the job
    assign finish = job_o.done || job_o.reject;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= buf_ring_pkg::HS_IDLE;
        end else begin
            case (state_q)
                buf_ring_pkg::HS_IDLE: begin
                    if (start) begin
                        state_q <= buf_ring_pkg::HS_BUSY;
                    end
                end
                buf_ring_pkg::HS_BUSY: begin
                    // Back to idle on the same edge that moves the token
                    // so ready follows the new head from the next cycle
                    if (finish) begin
                        state_q <= buf_ring_pkg::HS_IDLE;
                    end
                end
                default: begin
                    state_q <= buf_ring_pkg::HS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/owner_map.sv
`timescale 1ns/10ps
`default_nettype none

module owner_map (
    input  buf_ring_pkg::buf_tok_t     snoop_head_i,
    input  buf_ring_pkg::buf_tok_t     cpu_head_i,
    input  buf_ring_pkg::buf_tok_t     fwd_head_i,
    output buf_ring_pkg::owner_sel_t   owner_o
);

    // Finds which agent has the given buffer at the head of its queue.
    // Tokens are unique across the ring, so at most one head can match
    function automatic buf_ring_pkg::agent_e owner_of(
        input buf_ring_pkg::buf_tok_t tok,
        input buf_ring_pkg::buf_tok_t sn,
        input buf_ring_pkg::buf_tok_t cpu,
        input buf_ring_pkg::buf_tok_t fwd
    );
        if (sn == tok) begin
            return buf_ring_pkg::AG_SNOOP;
        end
        if (cpu == tok) begin
            return buf_ring_pkg::AG_CPU;
        end
        if (fwd == tok) begin
            return buf_ring_pkg::AG_FWD;
        end
        // Buffer is waiting behind some other head
        return buf_ring_pkg::AG_NONE;
    endfunction

    // Purely combinational, the muxes follow the heads in the same cycle
    assign owner_o.ping = owner_of(buf_ring_pkg::TOK_PING, snoop_head_i, cpu_head_i,
                                   fwd_head_i);
    assign owner_o.pang = owner_of(buf_ring_pkg::TOK_PANG, snoop_head_i, cpu_head_i,
                                   fwd_head_i);
    assign owner_o.pong = owner_of(buf_ring_pkg::TOK_PONG, snoop_head_i, cpu_head_i,
                                   fwd_head_i);

endmodule

`default_nettype wire

// File: hw/buf_ring_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module buf_ring_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    output logic                            snoop_rdy_o,
    input  wire logic                       snoop_rdy_ack_i,
    input  buf_ring_pkg::agent_result_e     snoop_result_i,
    output logic                            snoop_done_ack_o,
    output buf_ring_pkg::buf_tok_t          snoop_buf_o,
    output logic                            cpu_rdy_o,
    input  wire logic                       cpu_rdy_ack_i,
    input  buf_ring_pkg::agent_result_e     cpu_result_i,
    output logic                            cpu_done_ack_o,
    output buf_ring_pkg::buf_tok_t          cpu_buf_o,
    output logic                            fwd_rdy_o,
    input  wire logic                       fwd_rdy_ack_i,
    input  buf_ring_pkg::agent_result_e     fwd_result_i,
    output logic                            fwd_done_ack_o,
    output buf_ring_pkg::buf_tok_t          fwd_buf_o,
    output buf_ring_pkg::owner_sel_t        owner_o
);

    buf_ring_pkg::job_event_t snoop_job;
    buf_ring_pkg::job_event_t cpu_job;
    buf_ring_pkg::job_event_t fwd_job;

    logic                     snoop_enq     [2];
    buf_ring_pkg::buf_tok_t   snoop_enq_tok [2];
    logic                     cpu_enq       [1];
    buf_ring_pkg::buf_tok_t   cpu_enq_tok   [1];
    logic                     fwd_enq       [1];
    buf_ring_pkg::buf_tok_t   fwd_enq_tok   [1];

    // Snooper done hands the filled buffer to the CPU
    agent_handshake snoop_hs_inst (.clk(clk), .rst(rst),
        .connected_i(snoop_buf_o != buf_ring_pkg::TOK_NONE),
        .rdy_ack_i(snoop_rdy_ack_i), .result_i(snoop_result_i),
        .rdy_o(snoop_rdy_o), .done_ack_o(snoop_done_ack_o), .job_o(snoop_job));

    agent_handshake cpu_hs_inst (.clk(clk), .rst(rst),
        .connected_i(cpu_buf_o != buf_ring_pkg::TOK_NONE),
        .rdy_ack_i(cpu_rdy_ack_i), .result_i(cpu_result_i),
        .rdy_o(cpu_rdy_o), .done_ack_o(cpu_done_ack_o), .job_o(cpu_job));

    agent_handshake fwd_hs_inst (.clk(clk), .rst(rst),
        .connected_i(fwd_buf_o != buf_ring_pkg::TOK_NONE),
        .rdy_ack_i(fwd_rdy_ack_i), .result_i(fwd_result_i),
        .rdy_o(fwd_rdy_o), .done_ack_o(fwd_done_ack_o), .job_o(fwd_job));

    // Reject goes in ahead of forwarder done when both land together
    assign snoop_enq[0]     = cpu_job.reject;
    assign snoop_enq_tok[0] = cpu_buf_o;
    assign snoop_enq[1]     = fwd_job.done;
    assign snoop_enq_tok[1] = fwd_buf_o;
    assign cpu_enq[0]       = snoop_job.done;
    assign cpu_enq_tok[0]   = snoop_buf_o;
    assign fwd_enq[0]       = cpu_job.done;
    assign fwd_enq_tok[0]   = cpu_buf_o;

    token_queue #(.NUM_SRC(2), .INIT_FULL(1'b1)) snoop_q_inst (.clk(clk), .rst(rst),
        .enq_i(snoop_enq), .enq_tok_i(snoop_enq_tok), .deq_i(snoop_job.done),
        .head_o(snoop_buf_o));

    // The CPU gives its buffer up on either outcome
    token_queue #(.NUM_SRC(1), .INIT_FULL(1'b0)) cpu_q_inst (.clk(clk), .rst(rst),
        .enq_i(cpu_enq), .enq_tok_i(cpu_enq_tok),
        .deq_i(cpu_job.done || cpu_job.reject), .head_o(cpu_buf_o));

    token_queue #(.NUM_SRC(1), .INIT_FULL(1'b0)) fwd_q_inst (.clk(clk), .rst(rst),
        .enq_i(fwd_enq), .enq_tok_i(fwd_enq_tok), .deq_i(fwd_job.done),
        .head_o(fwd_buf_o));

    owner_map owner_map_inst (.snoop_head_i(snoop_buf_o), .cpu_head_i(cpu_buf_o),
        .fwd_head_i(fwd_buf_o), .owner_o(owner_o));

endmodule

`default_nettype wire

// File: tests/clk_rst_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock that starts low, so the first rising edge is at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset is held through the first few rising edges and released on an edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/buf_ring_chk.sv
`timescale 1ns/10ps
`default_nettype none

module buf_ring_chk (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    // Bit 0 is the snooper, bit 1 the CPU, bit 2 the forwarder
    input  wire logic [2:0]                rdy_i,
    input  wire logic [2:0]                done_ack_i,
    input  buf_ring_pkg::buf_tok_t [2:0]   head_i
);

    // An agent is either offered a buffer or being acked, never both
    a_rdy_ack_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        (rdy_i & done_ack_i) == 3'b000)
        else $error("ready and done-ack high together");

    // Ready may only come up while the agent holds a buffer
    for (genvar g = 0; g < 3; g++) begin : g_agent
        a_rdy_head: assert property (@(posedge clk_i) disable iff (rst_i)
            $rose(rdy_i[g]) |-> head_i[g] != buf_ring_pkg::TOK_NONE)
            else $error("ready rose for agent %0d with no buffer connected", g);
    end

    // A buffer is connected to one agent at most
    a_heads_unique: assert property (@(posedge clk_i) disable iff (rst_i)
        (head_i[0] == buf_ring_pkg::TOK_NONE ||
         (head_i[0] != head_i[1] && head_i[0] != head_i[2])) &&
        (head_i[1] == buf_ring_pkg::TOK_NONE || head_i[1] != head_i[2]))
        else $error("same buffer at the head of two queues");

endmodule

`default_nettype wire

// File: tests/buf_ring_tb.sv
`timescale 1ns/10ps
`default_nettype none

module buf_ring_tb;

    localparam int NUM_STEPS = 14;
    localparam int RESET_CYCLES = 5;
    // Each table row gets a fixed budget of cycles on top of the reset
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_STEPS * 40;

    // One row of the stimulus table
    typedef struct packed {
        buf_ring_pkg::agent_e        agent;
        buf_ring_pkg::agent_result_e res;
        logic [3:0]                  delay;
        logic                        rnd;
        logic                        early;
        logic                        pair;
    } step_t;

    // Columns are agent, result, ack delay, random delay, result raised while idle, and
    // pair, where a forwarder done completes in the same cycle as the CPU row
    step_t steps [NUM_STEPS] = '{
        '{buf_ring_pkg::AG_SNOOP, buf_ring_pkg::RES_DONE,   4'd0, 1'b0, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_CPU,   buf_ring_pkg::RES_DONE,   4'd1, 1'b0, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_SNOOP, buf_ring_pkg::RES_DONE,   4'd0, 1'b1, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_CPU,   buf_ring_pkg::RES_REJECT, 4'd0, 1'b0, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_FWD,   buf_ring_pkg::RES_DONE,   4'd2, 1'b0, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_SNOOP, buf_ring_pkg::RES_DONE,   4'd6, 1'b0, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_CPU,   buf_ring_pkg::RES_DONE,   4'd4, 1'b0, 1'b1, 1'b0},
        '{buf_ring_pkg::AG_SNOOP, buf_ring_pkg::RES_DONE,   4'd0, 1'b1, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_CPU,   buf_ring_pkg::RES_REJECT, 4'd0, 1'b0, 1'b0, 1'b1},
        '{buf_ring_pkg::AG_SNOOP, buf_ring_pkg::RES_DONE,   4'd0, 1'b1, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_CPU,   buf_ring_pkg::RES_DONE,   4'd0, 1'b0, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_SNOOP, buf_ring_pkg::RES_DONE,   4'd3, 1'b0, 1'b1, 1'b0},
        '{buf_ring_pkg::AG_FWD,   buf_ring_pkg::RES_DONE,   4'd0, 1'b1, 1'b0, 1'b0},
        '{buf_ring_pkg::AG_CPU,   buf_ring_pkg::RES_REJECT, 4'd0, 1'b1, 1'b0, 1'b0}
    };

    string names [NUM_STEPS] = '{"snoop_fill_ping", "cpu_accept_ping", "snoop_fill_pang",
        "cpu_reject_pang", "fwd_drain_ping", "snoop_late_ack_pong", "cpu_early_result_pong",
        "snoop_fill_pang_2", "cpu_reject_with_fwd_done", "snoop_fill_ping_2",
        "cpu_accept_ping_2", "snoop_early_result_pang", "fwd_drain_ping_2", "cpu_reject_tail"};

    logic                              clk;
    logic                              rst;
    // Index 0 is the snooper, 1 the CPU, 2 the forwarder
    logic [2:0]                        rdy_ack;
    buf_ring_pkg::agent_result_e       result [3];
    logic [2:0]                        rdy;
    logic [2:0]                        done_ack;
    buf_ring_pkg::buf_tok_t [2:0]      head;
    buf_ring_pkg::owner_sel_t          owner;
    // Reference model of the three token queues
    buf_ring_pkg::buf_tok_t            ref_q [3][$];
    string                             agent_names [3] = '{"snoop", "cpu", "fwd"};
    int                                seed = 32'he541;
    int                                errors = 0;
    int                                checks = 0;

    clk_rst_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) clk_rst_gen_inst (
        .clk_o(clk), .rst_o(rst));

    buf_ring_ctrl buf_ring_ctrl_inst (.clk(clk), .rst(rst),
        .snoop_rdy_o(rdy[0]), .snoop_rdy_ack_i(rdy_ack[0]), .snoop_result_i(result[0]),
        .snoop_done_ack_o(done_ack[0]), .snoop_buf_o(head[0]),
        .cpu_rdy_o(rdy[1]), .cpu_rdy_ack_i(rdy_ack[1]), .cpu_result_i(result[1]),
        .cpu_done_ack_o(done_ack[1]), .cpu_buf_o(head[1]),
        .fwd_rdy_o(rdy[2]), .fwd_rdy_ack_i(rdy_ack[2]), .fwd_result_i(result[2]),
        .fwd_done_ack_o(done_ack[2]), .fwd_buf_o(head[2]), .owner_o(owner));

    bind buf_ring_ctrl buf_ring_chk buf_ring_chk_inst (.clk_i(clk), .rst_i(rst),
        .rdy_i({fwd_rdy_o, cpu_rdy_o, snoop_rdy_o}),
        .done_ack_i({fwd_done_ack_o, cpu_done_ack_o, snoop_done_ack_o}),
        .head_i({fwd_buf_o, cpu_buf_o, snoop_buf_o}));

    task automatic check_val(input string name, input string what, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAIL %s: %s expected %0h got %0h", name, what, exp, got);
        end
    endtask

    // Each buffer belongs to the agent whose model queue has it in front
    function automatic buf_ring_pkg::owner_sel_t expected_owner();
        buf_ring_pkg::agent_e     own [4];
        buf_ring_pkg::owner_sel_t sel;
        for (int b = 0; b < 4; b++) begin
            own[b] = buf_ring_pkg::AG_NONE;
        end
        for (int i = 0; i < 3; i++) begin
            if (ref_q[i].size() != 0) begin
                own[ref_q[i][0]] = buf_ring_pkg::agent_e'(i + 1);
            end
        end
        sel.ping = own[1];
        sel.pang = own[2];
        sel.pong = own[3];
        return sel;
    endfunction

    task automatic compare_ring(input string name);
        buf_ring_pkg::buf_tok_t exp;
        for (int i = 0; i < 3; i++) begin
            exp = (ref_q[i].size() == 0) ? buf_ring_pkg::TOK_NONE : ref_q[i][0];
            check_val(name, {agent_names[i], " head"}, int'(exp), int'(head[i]));
        end
        check_val(name, "owner select", int'(expected_owner()), int'(owner));
    endtask

    task automatic move_token(input int src, input int dst);
        buf_ring_pkg::buf_tok_t tok;
        tok = ref_q[src].pop_front();
        ref_q[dst].push_back(tok);
    endtask

    // Called on a rising edge, so the new results land with the other inputs
    task automatic drive_results(input step_t st, input logic [2:0] mask);
        for (int i = 0; i < 3; i++) begin
            if (mask[i]) begin
                result[i] <= (i == 2 && st.pair) ? buf_ring_pkg::RES_DONE : st.res;
            end
        end
    endtask

    task automatic run_step(input int n);
        step_t      st;
        logic [2:0] mask;
        logic [2:0] exp_rdy;
        int         d;
        st = steps[n];
        mask = 3'b000;
        mask[int'(st.agent) - 1] = 1'b1;
        // The forwarder joins a pair row
        if (st.pair) begin
            mask[2] = 1'b1;
        end
        d = st.rnd ? int'($unsigned($random(seed)) % 8) : int'(st.delay);
        if (st.early) begin
            @(posedge clk);
            drive_results(st, mask);
        end
        do @(negedge clk); while ((rdy & mask) != mask);
        // While the ack is held back nothing may move, even with a result pending
        repeat (d) begin
            @(negedge clk);
            compare_ring({names[n], " waiting"});
            check_val(names[n], "done-ack before start", 0, int'(done_ack & mask));
            check_val(names[n], "ready held", int'(mask), int'(rdy & mask));
        end
        @(posedge clk);
        rdy_ack <= mask;
        @(posedge clk);
        rdy_ack <= 3'b000;
        if (!st.early) begin
            drive_results(st, mask);
        end
        do @(negedge clk); while ((done_ack & mask) != mask);
        // The completion happens on this edge, so the results drop with it
        @(posedge clk);
        for (int i = 0; i < 3; i++) begin
            if (mask[i]) begin
                result[i] <= buf_ring_pkg::RES_NONE;
            end
        end
        case (st.agent)
            buf_ring_pkg::AG_SNOOP: move_token(0, 1);
            buf_ring_pkg::AG_CPU:   move_token(1, (st.res == buf_ring_pkg::RES_REJECT) ? 0 : 2);
            default:                move_token(2, 0);
        endcase
        // Reject is written into the snoop queue ahead of forwarder done
        if (st.pair) begin
            move_token(2, 0);
        end
        @(negedge clk);
        compare_ring(names[n]);
        // Once idle again an agent is offered the next buffer waiting in its queue
        for (int i = 0; i < 3; i++) begin
            exp_rdy[i] = mask[i] && (ref_q[i].size() != 0);
        end
        check_val(names[n], "ready after completion", int'(exp_rdy), int'(rdy & mask));
        check_val(names[n], "done-ack after completion", 0, int'(done_ack & mask));
    endtask

    initial begin
        rdy_ack = 3'b000;
        for (int i = 0; i < 3; i++) begin
            result[i] = buf_ring_pkg::RES_NONE;
        end
        ref_q[0] = '{buf_ring_pkg::TOK_PING, buf_ring_pkg::TOK_PANG, buf_ring_pkg::TOK_PONG};
        do @(negedge clk); while (rst);
        compare_ring("reset");
        check_val("reset", "ready", 1, int'(rdy));
        check_val("reset", "done-ack", 0, int'(done_ack));
        for (int n = 0; n < NUM_STEPS; n++) begin
            run_step(n);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Ends a run that stalls on a handshake that never comes
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the DUT stopped answering before the last step");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hw/buf_ring_pkg.sv
hw/token_queue.sv
hw/agent_handshake.sv
hw/owner_map.sv
hw/buf_ring_ctrl.sv
tests/clk_rst_gen.sv
tests/buf_ring_chk.sv
tests/buf_ring_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the buffer ring testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module buf_ring_tb \
    -f sim.f --Mdir obj_dir -o buf_ring_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/buf_ring_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
